/* Bender.yml */
package:
  name: whiz_graphics

sources:
  - hw/lcdPkg.sv
  - hw/busDecoder.sv
  - hw/lcdRegisters.sv
  - hw/videoMemory.sv
  - hw/lineRenderer.sv
  - hw/whizGraphics.sv
  - target: simulation
    files:
      - sim/whizGraphicsTb.sv

/* hw/busDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module busDecoder
    import lcdPkg::*;
(
    input wire db,
    input wire reset,
    input wire busValid,
    input wire busWrite,
    input wire [15:0] busAddr,
    input wire [7:0] busWdata,
    input wire [7:0] regRdata,
    input wire [7:0] vramRdata,
    input wire vramReady,
    output logic busReady,
    output logic [7:0] busRdata,
    output logic busRvalid,
    output logic regValid,
    output logic vramValid,
    output logic tgtWrite,
    output logic [12:0] tgtOffset,
    output logic [7:0] tgtWdata
);

    logic vramHit;
    logic regHit;
    logic readAccept;
    logic readFromVram;
    logic readFromReg;

    assign vramHit = busAddr[15:13] == vramBase[15:13]; // 0x8000 to 0x9fff.
    assign regHit = busAddr[15:4] == regBase[15:4];

    assign regValid = busValid && regHit;
    assign vramValid = busValid && vramHit;
    assign busReady = vramHit ? vramReady : 1'b1; // Registers and holes never stall.

    assign tgtWrite = busWrite;
    assign tgtOffset = busAddr[12:0];
    assign tgtWdata = busWdata;

    assign readAccept = busValid && busReady && !busWrite;

    always_ff @(posedge db) begin
        if (reset) begin
            busRvalid <= 1'b0;
            readFromVram <= 1'b0;
            readFromReg <= 1'b0;
        end else begin
            busRvalid <= readAccept;
            if (readAccept) begin
                readFromVram <= vramHit;
                readFromReg <= regHit;
            end
        end
    end

    // Unmapped reads fall through to all ones.
    assign busRdata = readFromVram ? vramRdata : (readFromReg ? regRdata : 8'hff);

    targetOneHot: assert property (@(posedge db) disable iff (reset)
        !(regValid && vramValid));

endmodule

`default_nettype wire

/* hw/lcdPkg.sv */
`default_nettype none

package lcdPkg;

    localparam logic [15:0] vramBase = 16'h8000;
    localparam int vramDepth = 8192; // Addressed by a 13-bit offset.

    localparam logic [15:0] regBase = 16'hff40;
    localparam logic [3:0] lcdcOffset = 4'd0;
    localparam logic [3:0] scyOffset = 4'd2;
    localparam logic [3:0] scxOffset = 4'd3;
    localparam logic [3:0] lyOffset = 4'd4;
    localparam logic [3:0] bgpOffset = 4'd7;

    localparam logic [12:0] mapOffset0 = 13'h1800; // Map at 0x9800.
    localparam logic [12:0] mapOffset1 = 13'h1c00; // Map at 0x9c00.

    localparam int tileSize = 8;
    localparam int tileBytes = 16; // Two plane bytes per tile row.
    localparam int mapWidth = 32;

    typedef logic [1:0] Shade;

    // Only three flags steer the background; the rest are just storage.
    typedef struct packed {
        logic displayEnable;
        logic [2:0] spareHigh;
        logic tileMapSelect;
        logic [1:0] spareLow;
        logic bgEnable;
    } LcdFlags;

    typedef union packed {
        logic [7:0] raw;
        LcdFlags flags;
    } LcdControl;

endpackage

`default_nettype wire

/* hw/lcdRegisters.sv */
`timescale 1ns/1ns
`default_nettype none

module lcdRegisters
    import lcdPkg::*;
(
    input wire db,
    input wire reset,
    input wire regValid,
    input wire tgtWrite,
    input wire [12:0] tgtOffset,
    input wire [7:0] tgtWdata,
    input wire [7:0] ly,
    output logic [7:0] regRdata,
    output LcdControl lcdc,
    output logic [7:0] scy,
    output logic [7:0] scx,
    output logic [7:0] bgp
);

    logic [7:0] readByte;

    always_ff @(posedge db) begin
        if (reset) begin
            lcdc <= '0;
            scy <= '0;
            scx <= '0;
            bgp <= '0;
        end else if (regValid && tgtWrite) begin
            case (tgtOffset[3:0])
                lcdcOffset: lcdc.raw <= tgtWdata;
                scyOffset: scy <= tgtWdata;
                scxOffset: scx <= tgtWdata;
                bgpOffset: bgp <= tgtWdata;
                default: ; // LY and the holes ignore writes.
            endcase
        end
    end

    always_comb begin
        case (tgtOffset[3:0])
            lcdcOffset: readByte = lcdc.raw;
            scyOffset: readByte = scy;
            scxOffset: readByte = scx;
            lyOffset: readByte = ly; // Live line counter from the renderer.
            bgpOffset: readByte = bgp;
            default: readByte = 8'hff;
        endcase
    end

    always_ff @(posedge db) begin
        if (regValid && !tgtWrite) begin
            regRdata <= readByte;
        end
    end

endmodule

`default_nettype wire

/* hw/lineRenderer.sv */
`timescale 1ns/1ns
`default_nettype none

module lineRenderer
    import lcdPkg::*;
#(
    parameter int lineWidth = 160,
    parameter int numLines = 144
) (
    input wire db,
    input wire reset,
    input wire drawLine,
    input wire LcdControl lcdc,
    input wire [7:0] scy,
    input wire [7:0] scx,
    input wire [7:0] bgp,
    input wire [7:0] renderData,
    input wire pixelReady,
    output logic renderReq,
    output logic [12:0] renderAddr,
    output logic pixelValid,
    output Shade pixelShade,
    output logic [7:0] pixelX,
    output logic [7:0] ly,
    output logic lineDone,
    output logic renderComplete
);

    localparam logic [2:0] fetchIdle = 3'd0;
    localparam logic [2:0] fetchMap = 3'd1; // Map byte requested.
    localparam logic [2:0] fetchLow = 3'd2; // Map byte back, low plane requested.
    localparam logic [2:0] fetchHigh = 3'd3;
    localparam logic [2:0] fetchLast = 3'd4; // High plane byte arrives.

    logic active;
    logic firstTile;
    logic [2:0] fetchStep;
    logic bufFull;
    logic [3:0] shCount;
    logic [12:0] mapBase;
    logic [7:0] bgRow;
    logic [2:0] fineX;
    logic [4:0] tileCol;
    logic bgEn;
    logic [7:0] pal;
    logic [7:0] tileIdx;
    logic [7:0] bufLow;
    logic [7:0] bufHigh;
    logic [7:0] shLow;
    logic [7:0] shHigh;
    logic [2:0] firstShift;
    logic [1:0] colour;
    logic startLine;
    logic loadShift;
    logic xfer;
    logic lastPixel;

    assign startLine = drawLine && !active && lcdc.flags.displayEnable;
    assign loadShift = active && bufFull && shCount == 4'd0;
    assign xfer = pixelValid && pixelReady;
    assign lastPixel = xfer && pixelX == 8'(lineWidth - 1);
    assign firstShift = firstTile ? fineX : 3'd0; // Fine scroll drops the leading pixels.

    assign renderReq = fetchStep == fetchMap || fetchStep == fetchLow || fetchStep == fetchHigh;

    always_comb begin
        case (fetchStep)
            fetchMap: renderAddr = mapBase + 13'(bgRow[7:3]) * 13'(mapWidth) + 13'(tileCol);
            fetchLow: renderAddr = 13'(renderData) * 13'(tileBytes) + 13'({bgRow[2:0], 1'b0});
            default: renderAddr = 13'(tileIdx) * 13'(tileBytes) + 13'({bgRow[2:0], 1'b1});
        endcase
    end

    assign pixelValid = shCount != 4'd0;
    assign colour = bgEn ? {shHigh[7], shLow[7]} : 2'b00;
    assign pixelShade = pal[2 * colour +: 2];

    always_ff @(posedge db) begin
        if (reset) begin
            active <= 1'b0;
            firstTile <= 1'b0;
            fetchStep <= fetchIdle;
            bufFull <= 1'b0;
            shCount <= '0;
            pixelX <= '0;
            ly <= '0;
            lineDone <= 1'b0;
            renderComplete <= 1'b0;
        end else begin
            lineDone <= 1'b0;
            renderComplete <= 1'b0;
            if (startLine) begin
                active <= 1'b1;
                firstTile <= 1'b1;
                pixelX <= '0;
                fetchStep <= fetchMap;
            end else if (lastPixel) begin
                active <= 1'b0; // Any prefetch in flight is abandoned.
                fetchStep <= fetchIdle;
                bufFull <= 1'b0;
                shCount <= '0;
                lineDone <= 1'b1;
                renderComplete <= ly == 8'(numLines - 1);
                ly <= ly == 8'(numLines - 1) ? 8'd0 : ly + 8'd1;
            end else if (active) begin
                case (fetchStep)
                    fetchIdle: if (!bufFull) fetchStep <= fetchMap;
                    fetchMap: fetchStep <= fetchLow;
                    fetchLow: fetchStep <= fetchHigh;
                    fetchHigh: fetchStep <= fetchLast;
                    default: begin
                        fetchStep <= fetchIdle;
                        bufFull <= 1'b1;
                    end
                endcase
                if (loadShift) begin
                    bufFull <= 1'b0; // Frees the buffer for the next tile.
                    firstTile <= 1'b0;
                    shCount <= 4'd8 - {1'b0, firstShift};
                end else if (xfer) begin
                    shCount <= shCount - 4'd1;
                    pixelX <= pixelX + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge db) begin
        if (startLine) begin
            mapBase <= lcdc.flags.tileMapSelect ? mapOffset1 : mapOffset0;
            bgRow <= ly + scy;
            fineX <= scx[2:0];
            tileCol <= scx[7:3];
            bgEn <= lcdc.flags.bgEnable;
            pal <= bgp;
        end
        if (fetchStep == fetchLow) tileIdx <= renderData;
        if (fetchStep == fetchHigh) bufLow <= renderData;
        if (fetchStep == fetchLast) begin
            bufHigh <= renderData;
            tileCol <= tileCol + 5'd1; // Wraps around the 32-tile map row.
        end
        if (loadShift) begin
            shLow <= bufLow << firstShift;
            shHigh <= bufHigh << firstShift;
        end else if (xfer) begin
            shLow <= shLow << 1;
            shHigh <= shHigh << 1;
        end
    end

    pixelHold: assert property (@(posedge db) disable iff (reset)
        pixelValid && !pixelReady |=> pixelValid && $stable(pixelShade) && $stable(pixelX));

endmodule

`default_nettype wire

/* hw/videoMemory.sv */
`timescale 1ns/1ns
`default_nettype none

module videoMemory
    import lcdPkg::*;
(
    input wire db,
    input wire vramValid,
    input wire tgtWrite,
    input wire [12:0] tgtOffset,
    input wire [7:0] tgtWdata,
    input wire renderReq,
    input wire [12:0] renderAddr,
    output logic vramReady,
    output logic [7:0] vramRdata,
    output logic [7:0] renderData
);

    logic [7:0] mem [vramDepth];

    assign vramReady = !renderReq; // The renderer owns the port while it fetches.

    always_ff @(posedge db) begin
        if (renderReq) begin
            renderData <= mem[renderAddr];
        end else if (vramValid) begin
            if (tgtWrite) begin
                mem[tgtOffset] <= tgtWdata;
            end else begin
                vramRdata <= mem[tgtOffset];
            end
        end
    end

    // A stalled bus write is not consumed and must still be offered next cycle.
    stalledWriteRetries: assert property (@(posedge db)
        vramValid && tgtWrite && renderReq |=>
            vramValid && tgtWrite && $stable(tgtOffset) && $stable(tgtWdata));

endmodule

`default_nettype wire

/* hw/whizGraphics.sv */
`timescale 1ns/1ns
`default_nettype none

module whizGraphics
    import lcdPkg::*;
#(
    parameter int lineWidth = 160,
    parameter int numLines = 144
) (
    input wire db,
    input wire reset,
    input wire busValid,
    input wire busWrite,
    input wire [15:0] busAddr,
    input wire [7:0] busWdata,
    output logic busReady,
    output logic [7:0] busRdata,
    output logic busRvalid,
    input wire drawLine,
    output logic pixelValid,
    output Shade pixelShade,
    output logic [7:0] pixelX,
    input wire pixelReady,
    output logic [7:0] ly,
    output logic lineDone,
    output logic renderComplete
);

    logic regValid;
    logic vramValid;
    logic vramReady;
    logic tgtWrite;
    logic [12:0] tgtOffset;
    logic [7:0] tgtWdata;
    logic [7:0] regRdata;
    logic [7:0] vramRdata;
    LcdControl lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] bgp;
    logic renderReq;
    logic [12:0] renderAddr;
    logic [7:0] renderData;

    busDecoder decoder (
        .db, .reset, .busValid, .busWrite, .busAddr, .busWdata,
        .regRdata, .vramRdata, .vramReady,
        .busReady, .busRdata, .busRvalid,
        .regValid, .vramValid, .tgtWrite, .tgtOffset, .tgtWdata
    );

    lcdRegisters registers (
        .db, .reset, .regValid, .tgtWrite, .tgtOffset, .tgtWdata, .ly,
        .regRdata, .lcdc, .scy, .scx, .bgp
    );

    videoMemory vram (
        .db, .vramValid, .tgtWrite, .tgtOffset, .tgtWdata,
        .renderReq, .renderAddr,
        .vramReady, .vramRdata, .renderData
    );

    lineRenderer #(
        .lineWidth(lineWidth),
        .numLines(numLines)
    ) renderer (
        .db, .reset, .drawLine, .lcdc, .scy, .scx, .bgp, .renderData, .pixelReady,
        .renderReq, .renderAddr, .pixelValid, .pixelShade, .pixelX,
        .ly, .lineDone, .renderComplete
    );

endmodule

`default_nettype wire

/* sim/whizGraphicsTb.sv */
`timescale 1ns/1ns
`default_nettype none

module whizGraphicsTb;

    localparam int lineWidth = 32;
    localparam int numLines = 8;
    localparam int cycleLimit = 40 * lineWidth * numLines * 3 + 20000;

    logic db = 1'b0;
    logic reset = 1'b1;
    logic busValid = 1'b0;
    logic busWrite = 1'b0;
    logic [15:0] busAddr = '0;
    logic [7:0] busWdata = '0;
    logic drawLine = 1'b0;
    logic pixelReady = 1'b1;
    logic busReady, busRvalid, pixelValid, lineDone, renderComplete;
    logic [7:0] busRdata, pixelX, ly;
    logic [1:0] pixelShade;

    integer seed = 32'h327b;
    logic [7:0] vramModel [8192];
    logic [7:0] lcdcM = '0, scyM = '0, scxM = '0, bgpM = '0;
    int lyModel = 0, pixCount = 0, lineCount = 0, frameCount = 0, cycles = 0;
    int errors = 0, errorsAtStart = 0, testsRun = 0, testsFailed = 0;
    logic lineActive = 1'b0, stallMode = 1'b0, lineMapSel, lineBgEn;
    logic [7:0] lineScx, lineScy, lineBgp, lineLy, rd;
    logic [15:0] addrList [300];
    string testName = "reset";

    whizGraphics #(.lineWidth(lineWidth), .numLines(numLines)) dut (.*);

    always #50 db = ~db;

    always @(posedge db) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Timeout in %s: the run did not finish within %0d cycles.",
                     testName, cycleLimit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    always @(posedge db) begin
        #1 pixelReady = !stallMode || ($random(seed) & 1); // Random stalls only when asked.
    end

    function automatic int randomBelow(int n);
        return ($random(seed) & 32'h7fffffff) % n;
    endfunction

    function automatic logic isMapped(logic [15:0] addr);
        return addr[15:13] == 3'b100 || addr[15:4] == 12'hff4;
    endfunction

    function automatic logic [7:0] expectedRead(logic [15:0] addr);
        if (addr[15:13] == 3'b100) return vramModel[addr[12:0]];
        if (addr[15:4] != 12'hff4) return 8'hff;
        case (addr[3:0])
            4'd0: return lcdcM;
            4'd2: return scyM;
            4'd3: return scxM;
            4'd4: return 8'(lyModel);
            4'd7: return bgpM;
            default: return 8'hff;
        endcase
    endfunction

    // Background pixel from the scroll, the map, tile data at 0x8000 and the palette.
    function automatic logic [1:0] expectedShade(int x);
        logic [7:0] bgX, bgY, tile, lo, hi;
        logic [12:0] mapAddr, rowAddr;
        logic [1:0] colour;
        bgX = 8'(x) + lineScx;
        bgY = lineLy + lineScy;
        mapAddr = (lineMapSel ? 13'h1c00 : 13'h1800) + 13'(bgY[7:3]) * 13'd32 + 13'(bgX[7:3]);
        tile = vramModel[mapAddr];
        rowAddr = 13'(tile) * 13'd16 + 13'(bgY[2:0]) * 13'd2;
        lo = vramModel[rowAddr];
        hi = vramModel[rowAddr + 13'd1];
        colour = {hi[3'd7 - bgX[2:0]], lo[3'd7 - bgX[2:0]]};
        if (!lineBgEn) colour = 2'd0;
        return lineBgp[2 * colour +: 2];
    endfunction

    task automatic checkValue(string what, int expected, int actual);
        assert (expected == actual) else begin
            $display("** Error %s %s: expected %0h, actual %0h", testName, what, expected, actual);
            errors++;
        end
    endtask

    task automatic noteWrite(logic [15:0] addr, logic [7:0] data);
        if (addr[15:13] == 3'b100) vramModel[addr[12:0]] = data;
        else if (addr[15:4] == 12'hff4) begin
            case (addr[3:0])
                4'd0: lcdcM = data;
                4'd2: scyM = data;
                4'd3: scxM = data;
                4'd7: bgpM = data;
                default: ; // LY and holes drop writes.
            endcase
        end
    endtask

    // Called 1 ns after a rising edge; returns at the same point of a later cycle.
    task automatic busAccess(logic write, logic [15:0] addr, logic [7:0] wdata,
                             output logic [7:0] rdata);
        busValid = 1'b1;
        busWrite = write;
        busAddr = addr;
        busWdata = wdata;
        @(negedge db);
        // Only a video RAM request during a line can meet a fetch.
        assert (busReady || (lineActive && addr[15:13] == 3'b100)) else begin
            $display("Failure in %s: the request to %h was not accepted at once.",
                     testName, addr);
            errors++;
        end
        while (!busReady) @(negedge db);
        @(posedge db);
        #1 busValid = 1'b0;
        rdata = 8'hxx;
        if (write) noteWrite(addr, wdata);
        else begin
            @(negedge db);
            assert (busRvalid) else begin
                $display("Failure in %s: no busRvalid one cycle after reading %h.",
                         testName, addr);
                errors++;
            end
            rdata = busRdata;
            @(posedge db);
            #1;
        end
    endtask

    task automatic readCheck(string what, logic [15:0] addr);
        logic [7:0] data;
        busAccess(1'b0, addr, 8'h00, data);
        checkValue(what, expectedRead(addr), data);
    endtask

    task automatic busTraffic(int count);
        logic [15:0] addr;
        logic [7:0] data;
        repeat (count) begin
            addr = 16'h9000 + 16'(randomBelow(16'h0800)); // Outside tile data and maps.
            data = 8'($random(seed));
            busAccess(1'b1, addr, data, rd);
            readCheck("vram during render", addr);
        end
    endtask

    task automatic startLine();
        lineScx = scxM;
        lineScy = scyM;
        lineBgp = bgpM;
        lineMapSel = lcdcM[3];
        lineBgEn = lcdcM[0];
        lineLy = 8'(lyModel);
        pixCount = 0;
        lineActive = lcdcM[7];
        drawLine = 1'b1;
        @(posedge db);
        #1 drawLine = 1'b0;
    endtask

    task automatic waitLine();
        while (lineActive) @(negedge db);
        @(posedge db);
        #1;
    endtask

    task automatic randomView(logic [7:0] flags);
        busAccess(1'b1, 16'hff42, 8'($random(seed)), rd);
        busAccess(1'b1, 16'hff43, 8'($random(seed)), rd);
        busAccess(1'b1, 16'hff47, 8'($random(seed)), rd);
        busAccess(1'b1, 16'hff40, flags | (8'($random(seed)) & 8'h08), rd);
    endtask

    task automatic beginTest(string name);
        testName = name;
        errorsAtStart = errors;
    endtask

    task automatic endTest();
        testsRun++;
        if (errors > errorsAtStart) begin
            testsFailed++;
            $display("Test %s: %0d errors", testName, errors - errorsAtStart);
        end else begin
            $display("Test %s: ok", testName);
        end
    endtask

    always @(negedge db) begin
        if (!reset) begin
            assert (lineActive || !pixelValid) else begin
                $display("Failure in %s: pixelValid is high with no line in progress.", testName);
                errors++;
            end
            if (pixelValid && pixelReady && lineActive) begin
                checkValue("pixelX", pixCount, pixelX);
                checkValue($sformatf("shade at x %0d", pixCount), expectedShade(pixCount),
                           pixelShade);
                pixCount++;
            end
            assert (lineDone || !renderComplete) else begin
                $display("Failure in %s: renderComplete pulsed without lineDone.", testName);
                errors++;
            end
            if (lineDone) begin
                checkValue("pixels per line", lineWidth, pixCount);
                checkValue("renderComplete", lyModel == numLines - 1, renderComplete);
                lyModel = (lyModel == numLines - 1) ? 0 : lyModel + 1;
                lineCount++;
                if (renderComplete) frameCount++;
                lineActive = 1'b0;
            end
            checkValue("ly", lyModel, ly);
        end
    end

    initial begin
        repeat (5) @(posedge db);
        #1 reset = 1'b0;

        beginTest("registers");
        repeat (30) begin
            busAddr = 16'hff40 + 16'(randomBelow(8));
            busAccess(1'b1, busAddr, 8'($random(seed)), rd);
            readCheck("register readback", busAddr);
        end
        readCheck("ly", 16'hff44);
        repeat (10) begin
            busAddr = 16'($random(seed));
            while (isMapped(busAddr)) busAddr = 16'($random(seed));
            readCheck("unmapped", busAddr);
        end
        endTest();

        beginTest("vram");
        foreach (addrList[i]) begin
            addrList[i] = 16'h8000 + 16'(randomBelow(8192));
            busAccess(1'b1, addrList[i], 8'($random(seed)), rd);
        end
        foreach (addrList[i]) readCheck("vram readback", addrList[i]);
        endTest();

        beginTest("render");
        for (int a = 16'h8000; a < 16'ha000; a++) begin
            if (a < 16'h9000 || a >= 16'h9800) busAccess(1'b1, 16'(a), 8'($random(seed)), rd);
        end
        randomView(8'h81);
        repeat (numLines) begin
            startLine();
            waitLine();
        end
        endTest();

        beginTest("backpressure");
        stallMode = 1'b1;
        randomView(8'h81);
        repeat (numLines) begin
            startLine();
            fork
                waitLine();
                busTraffic(4);
            join
        end
        stallMode = 1'b0;
        endTest();

        beginTest("control");
        busAccess(1'b1, 16'hff40, 8'h01, rd); // Display off.
        startLine();
        repeat (200) @(posedge db);
        #1 busAccess(1'b1, 16'hff40, 8'h80, rd); // Background off.
        startLine();
        waitLine();
        busAccess(1'b1, 16'hff40, 8'h81, rd);
        startLine();
        busAccess(1'b1, 16'hff40, 8'h89, rd); // Map switch lands mid-line.
        waitLine();
        startLine();
        waitLine();
        endTest();

        beginTest("frames");
        repeat (5) begin
            randomView(8'h81);
            startLine();
            waitLine();
        end
        checkValue("lines drawn", 3 * numLines, lineCount);
        checkValue("frames completed", 3, frameCount);
        readCheck("ly after wrap", 16'hff44);
        endTest();

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hw/lcdPkg.sv
hw/busDecoder.sv
hw/lcdRegisters.sv
hw/videoMemory.sv
hw/lineRenderer.sv
hw/whizGraphics.sv
sim/whizGraphicsTb.sv
